//--- hdl/mdc_clock_gen.sv
`timescale 1ns/1ps
`include "mdio_defines.svh"

module mdc_clock_gen (
	input  logic i_clk,
	input  logic i_reset,
	output logic o_mdclk,
	output logic o_shift_stb
);

	localparam int CW = `MDIO_CLKBITS;

	// Count one before the wrap, decoded a clock early so the strobe is a flop
	localparam logic [CW-1:0] PRE_WRAP = CW'((2 ** CW) - 2);

	logic [CW-1:0] count;

	always_ff @(posedge i_clk)
		if (i_reset)
			count <= '0;
		else
			count <= count + 1'b1;

	// Top bit is MDC, so it falls when the counter wraps
	assign o_mdclk = count[CW-1];

	// High while count is all ones, last clock before MDC falls
	always_ff @(posedge i_clk)
		if (i_reset)
			o_shift_stb <= 1'b0;
		else
			o_shift_stb <= (count == PRE_WRAP);

endmodule

//--- hdl/mdio_bus_port.sv
`timescale 1ns/1ps
`include "mdio_defines.svh"

module mdio_bus_port import mdio_pkg::*; (
	input  logic                   i_clk,
	input  logic                   i_reset,

	// Register bus
	input  logic                   i_wb_cyc,
	input  logic                   i_wb_stb,
	input  logic                   i_wb_we,
	input  reg_addr_t              i_wb_addr,
	input  reg_data_t              i_wb_data,
	output logic                   o_wb_stall,
	output logic                   o_wb_ack,
	output logic [`MDIO_WB_DW-1:0] o_wb_data,

	// From the frame engine
	input  logic                   i_idle,
	input  logic                   i_in_data,
	input  logic                   i_done,
	input  reg_data_t              i_rd_data,

	// To the frame engine
	output logic                   o_rd_pending,
	output logic                   o_wr_pending,
	output reg_addr_t              o_reg_addr,
	output reg_data_t              o_wr_data
);

	logic idle_q;
	logic accepted;
	logic accept;

	assign accept = i_wb_stb && !o_wb_stall;

	// Engine idle, delayed by one clock
	always_ff @(posedge i_clk)
		if (i_reset)
			idle_q <= 1'b0;
		else
			idle_q <= i_idle;

	////////////////////////////////////////////////////////////////////////////
	//
	// Stall
	//
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
		if (i_reset)
			o_wb_stall <= 1'b1;
		else if (!i_idle)
			o_wb_stall <= 1'b1;
		else if (o_wb_ack)
			o_wb_stall <= 1'b0;
		else if ((i_wb_stb && idle_q) || o_rd_pending || o_wr_pending)
			o_wb_stall <= 1'b1;
		else
			o_wb_stall <= 1'b0;

	////////////////////////////////////////////////////////////////////////////
	//
	// Request capture
	//
	////////////////////////////////////////////////////////////////////////////

	// Address and data follow the bus until the stall freezes them
	always_ff @(posedge i_clk)
		if (!o_wb_stall)
		begin
			o_reg_addr <= i_wb_addr;
			o_wr_data  <= i_wb_data;
		end

	always_ff @(posedge i_clk)
		if (i_reset || i_in_data)
		begin
			o_rd_pending <= 1'b0;
			o_wr_pending <= 1'b0;
		end
		else if (accept)
		begin
			o_rd_pending <= !i_wb_we;
			o_wr_pending <= i_wb_we;
		end

	////////////////////////////////////////////////////////////////////////////
	//
	// Acknowledge
	//
	////////////////////////////////////////////////////////////////////////////

	// A dropped cycle forgets the request, the frame itself runs on
	always_ff @(posedge i_clk)
		if (i_reset || !i_wb_cyc)
			accepted <= 1'b0;
		else if (accept)
			accepted <= 1'b1;
		else if (o_wb_ack)
			accepted <= 1'b0;

	assign o_wb_ack  = i_done && accepted && i_wb_cyc;
	assign o_wb_data = {{(`MDIO_WB_DW - $bits(reg_data_t)){1'b0}}, i_rd_data};

endmodule

//--- hdl/mdio_ctrl_top.sv
`timescale 1ns/1ps
`include "mdio_defines.svh"

module mdio_ctrl_top import mdio_pkg::*; (
	input  logic                   i_clk,
	input  logic                   i_reset,

	// Register bus
	input  logic                   i_wb_cyc,
	input  logic                   i_wb_stb,
	input  logic                   i_wb_we,
	input  reg_addr_t              i_wb_addr,
	input  reg_data_t              i_wb_data,
	output logic                   o_wb_stall,
	output logic                   o_wb_ack,
	output logic [`MDIO_WB_DW-1:0] o_wb_data,

	// Management interface
	output logic                   o_mdclk,
	output logic                   o_mdio,
	output logic                   o_mdwe,
	input  logic                   i_mdio
);

	logic      shift_stb;
	logic      rd_pending;
	logic      wr_pending;
	reg_addr_t reg_addr;
	reg_data_t wr_data;
	logic      eng_idle;
	logic      eng_in_data;
	logic      eng_done;
	reg_data_t rd_data;

	mdc_clock_gen u_clock_gen (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.o_mdclk     (o_mdclk),
		.o_shift_stb (shift_stb)
	);

	mdio_bus_port u_bus_port (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_wb_cyc     (i_wb_cyc),
		.i_wb_stb     (i_wb_stb),
		.i_wb_we      (i_wb_we),
		.i_wb_addr    (i_wb_addr),
		.i_wb_data    (i_wb_data),
		.o_wb_stall   (o_wb_stall),
		.o_wb_ack     (o_wb_ack),
		.o_wb_data    (o_wb_data),
		.i_idle       (eng_idle),
		.i_in_data    (eng_in_data),
		.i_done       (eng_done),
		.i_rd_data    (rd_data),
		.o_rd_pending (rd_pending),
		.o_wr_pending (wr_pending),
		.o_reg_addr   (reg_addr),
		.o_wr_data    (wr_data)
	);

	mdio_frame_engine u_frame_engine (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_shift_stb  (shift_stb),
		.i_mdio       (i_mdio),
		.o_mdio       (o_mdio),
		.o_mdwe       (o_mdwe),
		.i_rd_pending (rd_pending),
		.i_wr_pending (wr_pending),
		.i_reg_addr   (reg_addr),
		.i_wr_data    (wr_data),
		.o_idle       (eng_idle),
		.o_in_data    (eng_in_data),
		.o_done       (eng_done),
		.o_rd_data    (rd_data)
	);

endmodule

//--- hdl/mdio_defines.svh
`ifndef MDIO_DEFINES_SVH
`define MDIO_DEFINES_SVH

// Management clock divider, MDC runs at i_clk / 2**MDIO_CLKBITS
`define MDIO_CLKBITS		2

`define MDIO_PHYADDR		5'h01
`define MDIO_PREAMBLE_BITS	64
`define MDIO_WB_DW		32

// Frame header: start + opcode, PHY address, register address, turnaround
`define MDIO_HDR_BITS		16
`define MDIO_DATA_BITS		16
`define MDIO_OP_RD		4'b0110
`define MDIO_OP_WR		4'b0101
`define MDIO_TA_RD		2'b11
`define MDIO_TA_WR		2'b10

`endif

//--- hdl/mdio_frame_engine.sv
`timescale 1ns/1ps
`include "mdio_defines.svh"

module mdio_frame_engine import mdio_pkg::*; (
	input  logic      i_clk,
	input  logic      i_reset,
	input  logic      i_shift_stb,

	// PHY side
	input  logic      i_mdio,
	output logic      o_mdio,
	output logic      o_mdwe,

	// Request from the bus port
	input  logic      i_rd_pending,
	input  logic      i_wr_pending,
	input  reg_addr_t i_reg_addr,
	input  reg_data_t i_wr_data,

	// Status back to the bus port
	output logic      o_idle,
	output logic      o_in_data,
	output logic      o_done,
	output reg_data_t o_rd_data
);

	frame_state_t state;
	bit_pos_t     pos;
	logic         pos_zero;
	reg_data_t    header;
	reg_data_t    tx_shift;

	assign pos_zero  = (pos == '0);
	assign o_idle    = (state == IDLE);
	assign o_in_data = (state == READ) || (state == WRITE);

	always_comb
		if (i_wr_pending)
			header = {`MDIO_OP_WR, `MDIO_PHYADDR, i_reg_addr, `MDIO_TA_WR};
		else
			header = {`MDIO_OP_RD, `MDIO_PHYADDR, i_reg_addr, `MDIO_TA_RD};

	////////////////////////////////////////////////////////////////////////////
	//
	// Sequencer
	//
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			state  <= RESET;
			pos    <= bit_pos_t'(`MDIO_PREAMBLE_BITS - 1);
			o_mdwe <= 1'b1;
			o_done <= 1'b0;
		end
		else
		begin
			o_done <= 1'b0;
			case (state)
			RESET:
			begin
				// All-ones preamble, one bit per strobe
				o_mdwe <= 1'b1;
				if (i_shift_stb)
				begin
					if (pos_zero)
						state <= IDLE;
					else
						pos <= pos - 1'b1;
				end
			end
			IDLE:
			begin
				o_mdwe <= 1'b1;
				pos    <= bit_pos_t'(`MDIO_HDR_BITS - 1);
				if (i_shift_stb && (i_rd_pending || i_wr_pending))
					state <= ADDRESS;
			end
			ADDRESS:
			begin
				if (i_shift_stb)
				begin
					// Let go of the line for both turnaround bits of a read
					o_mdwe <= i_wr_pending || (pos > bit_pos_t'(1));
					if (pos_zero)
					begin
						pos   <= bit_pos_t'(`MDIO_DATA_BITS);
						state <= i_wr_pending ? WRITE : READ;
					end
					else
						pos <= pos - 1'b1;
				end
			end
			READ,
			WRITE:
			begin
				o_mdwe <= (state == WRITE);
				if (i_shift_stb)
				begin
					// 16 data bits plus one trailing period
					if (pos_zero)
					begin
						state  <= IDLE;
						o_done <= 1'b1;
					end
					else
						pos <= pos - 1'b1;
				end
			end
			default:
			begin
				state  <= RESET;
				pos    <= bit_pos_t'(`MDIO_PREAMBLE_BITS - 1);
				o_mdwe <= 1'b1;
			end
			endcase
		end

	////////////////////////////////////////////////////////////////////////////
	//
	// Transmit shifter
	//
	////////////////////////////////////////////////////////////////////////////

	// Ones fill in behind, so the line idles high once a frame is out
	always_ff @(posedge i_clk)
		case (state)
		RESET:
			tx_shift <= '1;
		IDLE:
			tx_shift <= header;
		ADDRESS:
		begin
			if (i_shift_stb)
			begin
				if (pos_zero)
					tx_shift <= i_wr_data;
				else
					tx_shift <= {tx_shift[`MDIO_HDR_BITS-2:0], 1'b1};
			end
		end
		default:
		begin
			if (i_shift_stb)
				tx_shift <= {tx_shift[`MDIO_HDR_BITS-2:0], 1'b1};
		end
		endcase

	// Changes on the strobe, right at the falling edge of MDC
	always_ff @(posedge i_clk)
		if (i_reset)
			o_mdio <= 1'b1;
		else if (i_shift_stb)
			o_mdio <= (state == IDLE) || tx_shift[`MDIO_HDR_BITS-1];

	////////////////////////////////////////////////////////////////////////////
	//
	// Read capture
	//
	////////////////////////////////////////////////////////////////////////////

	// Sampled just before MDC falls, half a period after the PHY moved the line
	always_ff @(posedge i_clk)
		if (i_shift_stb && !pos_zero)
			o_rd_data <= {o_rd_data[`MDIO_DATA_BITS-2:0], i_mdio};

endmodule

//--- hdl/mdio_pkg.sv
package mdio_pkg;

	////////////////////////////////////////////////////////////////////////////
	//
	// Register bus payloads
	//
	////////////////////////////////////////////////////////////////////////////

	// Clause-22 register number
	typedef logic [4:0]  reg_addr_t;

	// One PHY register
	typedef logic [15:0] reg_data_t;

	// Counts bits left in the current frame phase, wide enough for the preamble
	typedef logic [5:0]  bit_pos_t;

	////////////////////////////////////////////////////////////////////////////
	//
	// Frame sequencer
	//
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		RESET   = 3'd0,
		IDLE    = 3'd1,
		ADDRESS = 3'd2,
		READ    = 3'd3,
		WRITE   = 3'd4
	} frame_state_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# Build and run the MDIO controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sources.f \
	--top-module tb_mdio_ctrl -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "TEST PASSED"; then
	exit 0
else
	exit 1
fi

//--- sources.f
+incdir+hdl
hdl/mdio_pkg.sv
hdl/mdc_clock_gen.sv
hdl/mdio_bus_port.sv
hdl/mdio_frame_engine.sv
hdl/mdio_ctrl_top.sv
tb/mdio_phy_model.sv
tb/tb_mdio_ctrl.sv

//--- tb/mdio_phy_model.sv
`timescale 1ns/1ps

module mdio_phy_model import mdio_pkg::*; (
	input  logic      i_mdclk,
	input  logic      i_mdio,
	input  logic      i_mdwe,
	output logic      o_mdio,
	output int        o_frame_count,
	output logic      o_frame_write,
	output reg_addr_t o_frame_phy,
	output reg_addr_t o_frame_reg
);

	reg_data_t   regs [0:31];
	logic [12:0] hdr;
	reg_data_t   wdata;
	reg_data_t   rdata;
	logic        frame_ok;
	int          nbits;
	int          phase;

	// Phases: 0 hunt for start, 1 header, 2 write turnaround and data, 3 read data
	initial
	begin
		for (int i = 0; i < 32; i++)
			regs[i] = reg_data_t'(i * 16'h0b1d) ^ 16'h5a5a;
		o_mdio        = 1'b1;
		o_frame_count = 0;
		o_frame_write = 1'b0;
		o_frame_phy   = '0;
		o_frame_reg   = '0;
		phase         = 0;
		nbits         = 0;
		hdr           = '0;
		wdata         = '0;
		rdata         = '0;
		frame_ok      = 1'b0;
	end

	always @(posedge i_mdclk)
	begin
		case (phase)
		0:
		begin
			if (i_mdwe === 1'b1 && i_mdio === 1'b0)
			begin
				hdr   = '0;
				nbits = 1;
				phase = 1;
			end
		end
		1:
		begin
			if (i_mdwe)
			begin
				hdr   = {hdr[11:0], i_mdio};
				nbits = nbits + 1;
				if (nbits == 14)
				begin
					o_frame_phy   = hdr[9:5];
					o_frame_reg   = hdr[4:0];
					o_frame_write = (hdr[11:10] == 2'b01);
					nbits         = 0;
					// Second start bit must be 1 and the opcode 01 or 10
					if (hdr[12] !== 1'b1 || hdr[11] === hdr[10])
						phase = 0;
					else if (hdr[11:10] == 2'b01)
						phase = 2;
					else
					begin
						rdata    = regs[hdr[4:0]];
						frame_ok = 1'b1;
						phase    = 3;
					end
				end
			end
		end
		2:
		begin
			if (i_mdwe)
			begin
				nbits = nbits + 1;
				// Write turnaround is 1 then 0 ahead of the data
				if (nbits == 1)
					frame_ok = (i_mdio === 1'b1);
				else if (nbits == 2)
					frame_ok = frame_ok && (i_mdio === 1'b0);
				else
					wdata = {wdata[14:0], i_mdio};
				if (nbits == 18)
				begin
					if (frame_ok)
					begin
						regs[o_frame_reg] = wdata;
						o_frame_count     = o_frame_count + 1;
					end
					phase = 0;
				end
			end
		end
		default:
		begin
			nbits = nbits + 1;
			// Controller keeps the line released through turnaround and data
			if (i_mdwe !== 1'b0)
				frame_ok = 1'b0;
			if (nbits >= 2 && nbits <= 17)
				o_mdio <= #1 rdata[17 - nbits];
			else if (nbits == 18)
			begin
				o_mdio <= #1 1'b1;
				if (frame_ok)
					o_frame_count = o_frame_count + 1;
				phase = 0;
			end
		end
		endcase
	end

endmodule

//--- tb/tb_mdio_ctrl.sv
`timescale 1ns/1ps
`include "mdio_defines.svh"

module tb_mdio_ctrl import mdio_pkg::*; ();

	localparam int N_RANDOM    = 200;
	localparam int N_TRANS     = N_RANDOM + 10;
	localparam int MDC_NS      = 40;
	localparam int WATCHDOG_NS = (N_TRANS + 2) * 40 * MDC_NS;
	localparam int TIMEOUT_CLK = 400;

	logic                   clk;
	logic                   reset;
	logic                   wb_cyc;
	logic                   wb_stb;
	logic                   wb_we;
	reg_addr_t              wb_addr;
	reg_data_t              wb_data;
	logic                   wb_stall;
	logic                   wb_ack;
	logic [`MDIO_WB_DW-1:0] wb_rdata;
	logic                   mdclk;
	logic                   mdio_out;
	logic                   mdwe;
	logic                   mdio_in;
	int                     frame_count;
	logic                   frame_write;
	reg_addr_t              frame_phy;
	reg_addr_t              frame_reg;

	reg_data_t model_regs [0:31];
	integer    seed;
	int        errors;
	int        checks;
	int        ack_count;
	int        test_start;

	mdio_ctrl_top dut (
		.i_clk      (clk),
		.i_reset    (reset),
		.i_wb_cyc   (wb_cyc),
		.i_wb_stb   (wb_stb),
		.i_wb_we    (wb_we),
		.i_wb_addr  (wb_addr),
		.i_wb_data  (wb_data),
		.o_wb_stall (wb_stall),
		.o_wb_ack   (wb_ack),
		.o_wb_data  (wb_rdata),
		.o_mdclk    (mdclk),
		.o_mdio     (mdio_out),
		.o_mdwe     (mdwe),
		.i_mdio     (mdio_in)
	);

	mdio_phy_model u_phy (
		.i_mdclk       (mdclk),
		.i_mdio        (mdio_out),
		.i_mdwe        (mdwe),
		.o_mdio        (mdio_in),
		.o_frame_count (frame_count),
		.o_frame_write (frame_write),
		.o_frame_phy   (frame_phy),
		.o_frame_reg   (frame_reg)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	always @(negedge clk)
		if (wb_ack === 1'b1)
			ack_count = ack_count + 1;

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the run did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	//
	// Compare tasks
	//
	////////////////////////////////////////////////////////////////////////////

	task automatic check_rdata(input logic [`MDIO_WB_DW-1:0] got, input reg_data_t exp,
		input string what);
		checks++;
		if (got !== {{(`MDIO_WB_DW - 16){1'b0}}, exp})
		begin
			errors++;
			$display("FAILED at %0t: %s data %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input reg_addr_t got, input reg_addr_t exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at %0t: %s address %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		checks++;
		if (got != exp)
		begin
			errors++;
			$display("FAILED at %0t: %s count %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic finish_test(input string name);
		$display("test %s: %s (%0d errors)", name, (errors == test_start) ? "ok" : "failed",
			errors - test_start);
		test_start = errors;
	endtask

	////////////////////////////////////////////////////////////////////////////
	//
	// Bus driver
	//
	////////////////////////////////////////////////////////////////////////////

	task automatic run_xfer(input logic we, input reg_addr_t addr, input reg_data_t data,
		input bit hold_stb, input int drop_after, output logic [`MDIO_WB_DW-1:0] rdata);
		int     n;
		integer r;
		rdata = '0;
		@(posedge clk);
		#1;
		wb_cyc  = 1'b1;
		wb_stb  = 1'b1;
		wb_we   = we;
		wb_addr = addr;
		wb_data = data;
		n = 0;
		@(negedge clk);
		while (wb_stall && n < TIMEOUT_CLK)
		begin
			@(negedge clk);
			n++;
		end
		if (wb_stall)
		begin
			errors++;
			$display("Request was never accepted, the bus stayed stalled");
			wb_cyc = 1'b0;
			wb_stb = 1'b0;
			return;
		end
		@(posedge clk);
		#1;
		if (hold_stb)
		begin
			// Further strobes while stalled must be ignored
			r       = $random(seed);
			wb_we   = r[0];
			wb_addr = r[8:4];
			wb_data = r[31:16];
		end
		else
			wb_stb = 1'b0;
		if (drop_after > 0)
		begin
			repeat (drop_after)
				@(posedge clk);
			#1;
			wb_cyc = 1'b0;
			wb_stb = 1'b0;
			return;
		end
		n = 0;
		@(negedge clk);
		while (!wb_ack && n < TIMEOUT_CLK)
		begin
			@(negedge clk);
			n++;
		end
		if (!wb_ack)
		begin
			errors++;
			$display("No acknowledge arrived for an accepted request");
		end
		else
			rdata = wb_rdata;
		@(posedge clk);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	// One full transaction, checked against the frame seen by the PHY and the model
	task automatic do_op(input logic we, input reg_addr_t addr, input reg_data_t data,
		input bit hold_stb);
		int                     frames_before;
		int                     acks_before;
		logic [`MDIO_WB_DW-1:0] rdata;
		frames_before = frame_count;
		acks_before   = ack_count;
		run_xfer(we, addr, data, hold_stb, 0, rdata);
		check_count(frame_count, frames_before + 1, "Frame");
		check_count(ack_count, acks_before + 1, "Acknowledge");
		check_flag(frame_write, we, "Frame write opcode");
		check_addr(frame_phy, 5'd1, "Frame PHY");
		check_addr(frame_reg, addr, "Frame register");
		if (we)
		begin
			model_regs[addr] = data;
			check_rdata({16'h0, u_phy.regs[addr]}, data, "PHY register");
		end
		else
			check_rdata(rdata, model_regs[addr], "Bus read");
	endtask

	////////////////////////////////////////////////////////////////////////////
	//
	// Test sequence
	//
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int                     n;
		int                     bad;
		int                     frames_before;
		int                     acks_before;
		integer                 r;
		reg_addr_t              addr;
		reg_data_t              data;
		logic [`MDIO_WB_DW-1:0] rdata;

		seed       = 32'hd76e_9b6a;
		errors     = 0;
		checks     = 0;
		ack_count  = 0;
		test_start = 0;
		reset      = 1'b1;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_addr    = '0;
		wb_data    = '0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = reg_data_t'(i * 16'h0b1d) ^ 16'h5a5a;

		repeat (8)
			@(posedge clk);
		#1;
		reset = 1'b0;

		// Preamble: 64 MDC periods of 4 clocks with the line held high
		n   = 0;
		bad = 0;
		@(negedge clk);
		while (wb_stall && n < TIMEOUT_CLK)
		begin
			// MDC starts low for two clocks out of reset, then high for two
			if (mdio_out !== 1'b1 || mdwe !== 1'b1 || wb_ack !== 1'b0 ||
				mdclk !== ((n % 4) >= 2))
				bad++;
			n++;
			@(negedge clk);
		end
		if (wb_stall)
		begin
			errors++;
			$display("Stall never fell after the preamble");
		end
		else if (n < 252 || n > 264)
		begin
			errors++;
			$display("Stall fell after %0d clocks, the preamble takes 256", n);
		end
		if (bad > 0)
		begin
			errors++;
			$display("Line, enable, clock or acknowledge was wrong during the preamble");
		end
		check_count(frame_count, 0, "Preamble frame");
		finish_test("preamble");

		r    = $random(seed);
		addr = r[4:0];
		data = r[31:16];
		do_op(1'b1, addr, data, 1'b0);
		finish_test("single write");

		do_op(1'b0, addr, 16'h0, 1'b0);
		finish_test("read back");

		for (int i = 0; i < N_RANDOM; i++)
		begin
			r = $random(seed);
			do_op(r[0], r[8:4], r[31:16], 1'b0);
		end
		finish_test("random mix");

		r = $random(seed);
		frames_before = frame_count;
		acks_before   = ack_count;
		do_op(1'b1, r[4:0], r[31:16], 1'b1);
		repeat (200)
			@(posedge clk);
		check_count(frame_count, frames_before + 1, "Stalled strobe frame");
		check_count(ack_count, acks_before + 1, "Stalled strobe acknowledge");
		finish_test("stalled strobes");

		r    = $random(seed);
		addr = r[4:0];
		data = r[31:16];
		frames_before = frame_count;
		acks_before   = ack_count;
		run_xfer(1'b1, addr, data, 1'b0, 1 + (r[10:6] % 20), rdata);
		// A new cycle without a strobe must not pick up the dropped acknowledge
		@(posedge clk);
		#1;
		wb_cyc = 1'b1;
		n = 0;
		while (frame_count == frames_before && n < TIMEOUT_CLK)
		begin
			@(negedge clk);
			n++;
		end
		if (frame_count == frames_before)
		begin
			errors++;
			$display("Write with dropped cycle never reached the PHY");
		end
		n = 0;
		@(negedge clk);
		while (wb_stall && n < TIMEOUT_CLK)
		begin
			@(negedge clk);
			n++;
		end
		check_count(ack_count, acks_before, "Dropped cycle acknowledge");
		@(posedge clk);
		#1;
		wb_cyc = 1'b0;
		model_regs[addr] = data;
		check_rdata({16'h0, u_phy.regs[addr]}, data, "Dropped cycle PHY register");
		do_op(1'b0, addr, 16'h0, 1'b0);
		finish_test("dropped cycle");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
